/* rtl/snd_pkg.sv */
// sample widths and rate plan; every rate must be a power of two and fm_w must equal snd_w
`default_nettype none

package snd_pkg;

    // sample widths
    localparam int fm_w  = 16;   // fm sample, signed
    localparam int psg_w = 12;   // psg sample, signed
    localparam int snd_w = 16;   // mixed and output word

    // clocks per sample in each rate domain
    localparam int in_period  = 32;  // input rate
    localparam int mid_period = 8;   // after stage 1
    localparam int out_period = 2;   // output rate

    // first cic stage
    localparam int s1_rate  = 4;
    localparam int s1_order = 1;     // plain hold

    // second cic stage
    localparam int s2_rate  = 4;
    localparam int s2_order = 2;     // linear interpolation

endpackage

`default_nettype wire

/* rtl/apb_reg_pkg.sv */
// APB register map of the up-rate block; 8-bit byte addresses, 32-bit data, zero wait states
`default_nettype none

package apb_reg_pkg;

    localparam int apb_aw = 8;    // address bits
    localparam int apb_dw = 32;   // data bits

    // mapped registers, word aligned
    typedef enum logic [apb_aw-1:0] {
        ctrl_addr   = 8'h00,
        status_addr = 8'h04,
        id_addr     = 8'h08
    } reg_addr_e;

    // CTRL fields
    localparam int ctrl_fm_en_bit  = 0;
    localparam int ctrl_psg_en_bit = 1;
    localparam int ctrl_att_lsb    = 2;
    localparam int ctrl_att_w      = 2;   // psg shift 0..3

    // STATUS fields
    localparam int status_clip_bit = 0;   // sticky, write 1 to clear

    // reset values
    localparam logic                  ctrl_fm_en_rst  = 1'b1;
    localparam logic                  ctrl_psg_en_rst = 1'b1;
    localparam logic [ctrl_att_w-1:0] ctrl_att_rst    = '0;
    localparam logic [apb_dw-1:0]     id_value        = 32'h464d_5552;  // "FMUR"

    typedef enum logic [1:0] {idle, setup, access} apb_phase_e;

endpackage

`default_nettype wire

/* rtl/mix_cfg_if.sv */
// mixer control and clip status between register block and mixer; clip is a one cycle pulse
`timescale 1ns/1ps
`default_nettype none

interface mix_cfg_if;

    logic       fm_en;     // fm source on
    logic       psg_en;    // psg source on
    logic [1:0] psg_att;   // psg right shift
    logic       clip;      // pulse per saturated sum

    modport regs (
        output fm_en,
        output psg_en,
        output psg_att,
        input  clip
    );

    modport mixer (
        input  fm_en,
        input  psg_en,
        input  psg_att,
        output clip
    );

endinterface

`default_nettype wire

/* rtl/apb_cfg_regs.sv */
// APB config slave without wait states; unmapped addresses give pslverr, read 0 and never write
`timescale 1ns/1ps
`default_nettype none

module apb_cfg_regs (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  [apb_reg_pkg::apb_aw-1:0]  paddr,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire  [apb_reg_pkg::apb_dw-1:0]  pwdata,
    output logic [apb_reg_pkg::apb_dw-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr,
    mix_cfg_if.regs                         cfg
);
    import apb_reg_pkg::*;

    apb_phase_e             bus_phase;  // phase on the bus now
    apb_phase_e             phase_q;    // phase one cycle back
    reg_addr_e              addr;
    logic                   addr_ok;
    logic                   wr_en;
    logic                   fm_en_q;
    logic                   psg_en_q;
    logic [ctrl_att_w-1:0]  psg_att_q;
    logic                   clip_q;     // sticky clip flag

    always_comb begin
        if (!psel) begin
            bus_phase = idle;
        end else if (!penable) begin
            bus_phase = setup;
        end else begin
            bus_phase = access;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= idle;
        end else begin
            phase_q <= bus_phase;
        end
    end

    // address decode
    assign addr = reg_addr_e'(paddr);

    always_comb begin
        case (addr)
            ctrl_addr, status_addr, id_addr: addr_ok = 1'b1;
            default:                         addr_ok = 1'b0;
        endcase
    end

    // write lands at the end of a proper access phase
    assign wr_en   = (bus_phase == access) && (phase_q == setup) && pwrite && addr_ok;
    assign pready  = 1'b1;                                  // zero wait
    assign pslverr = (bus_phase == access) && !addr_ok;

    // CTRL
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fm_en_q   <= ctrl_fm_en_rst;
            psg_en_q  <= ctrl_psg_en_rst;
            psg_att_q <= ctrl_att_rst;
        end else if (wr_en && addr == ctrl_addr) begin
            fm_en_q   <= pwdata[ctrl_fm_en_bit];
            psg_en_q  <= pwdata[ctrl_psg_en_bit];
            psg_att_q <= pwdata[ctrl_att_lsb +: ctrl_att_w];
        end
    end

    // STATUS
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clip_q <= 1'b0;
        end else if (cfg.clip) begin
            clip_q <= 1'b1;                                  // new clip beats a clear
        end else if (wr_en && addr == status_addr && pwdata[status_clip_bit]) begin
            clip_q <= 1'b0;                                  // write 1 to clear
        end
    end

    // read mux, unmapped reads 0
    always_comb begin
        prdata = '0;
        case (addr)
            ctrl_addr: begin
                prdata[ctrl_fm_en_bit]                = fm_en_q;
                prdata[ctrl_psg_en_bit]               = psg_en_q;
                prdata[ctrl_att_lsb +: ctrl_att_w]    = psg_att_q;
            end
            status_addr: prdata[status_clip_bit] = clip_q;
            id_addr:     prdata = id_value;
            default:     prdata = '0;
        endcase
    end

    assign cfg.fm_en   = fm_en_q;
    assign cfg.psg_en  = psg_en_q;
    assign cfg.psg_att = psg_att_q;

    // bus protocol checks
    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel);
    a_access_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_phase == access) |-> (phase_q == setup));

endmodule

`default_nettype wire

/* rtl/snd_mixer.sv */
// fm + psg mixer updated on cen_in; psg is doubled before attenuation and the sum saturates to snd_w
`timescale 1ns/1ps
`default_nettype none

module snd_mixer (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cen_in,
    input  wire  signed [snd_pkg::fm_w-1:0]     fm_snd,
    input  wire  signed [snd_pkg::psg_w-1:0]    psg_snd,
    mix_cfg_if.mixer                            cfg,
    output logic signed [snd_pkg::snd_w-1:0]    mixed
);
    import snd_pkg::*;

    localparam int sum_w = snd_w + 1;   // one guard bit for overflow
    localparam logic signed [snd_w-1:0] sat_max = {1'b0, {(snd_w-1){1'b1}}};
    localparam logic signed [snd_w-1:0] sat_min = {1'b1, {(snd_w-1){1'b0}}};

    logic signed [sum_w-1:0] fm_ext;
    logic signed [sum_w-1:0] psg_ext;
    logic signed [sum_w-1:0] psg_sh;
    logic signed [sum_w-1:0] sum;
    logic                    sat;

    always_comb begin
        fm_ext  = {{(sum_w-fm_w){fm_snd[fm_w-1]}}, fm_snd};
        psg_ext = {{(sum_w-psg_w-1){psg_snd[psg_w-1]}}, psg_snd, 1'b0};  // doubled with sign kept
        psg_sh  = psg_ext >>> cfg.psg_att;                               // arithmetic
        if (!cfg.fm_en) begin
            fm_ext = '0;
        end
        if (!cfg.psg_en) begin
            psg_sh = '0;
        end
        sum = fm_ext + psg_sh;
        sat = sum[sum_w-1] != sum[sum_w-2];   // top two bits disagree
    end

    // result taken on cen_in and held for a full input period
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mixed    <= '0;
            cfg.clip <= 1'b0;
        end else begin
            cfg.clip <= cen_in && sat;        // one cycle pulse
            if (cen_in) begin
                if (sat) begin
                    mixed <= sum[sum_w-1] ? sat_min : sat_max;
                end else begin
                    mixed <= sum[snd_w-1:0];
                end
            end
        end
    end

    // only both sources together pass full scale and the clamp takes the fm sign
    a_clip_after_cen: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.clip |-> $past(cen_in && cfg.fm_en && cfg.psg_en)
                     && (mixed[snd_w-1] == $past(fm_snd[fm_w-1])));

endmodule

`default_nettype wire

/* rtl/cic_interp.sv */
// cic interpolator; rate must be a power of two, order 1 to 3, cen_in must coincide with a cen_out
`timescale 1ns/1ps
`default_nettype none

module cic_interp #(
    parameter int rate  = 4,   // up-sampling factor
    parameter int order = 1    // comb and integrator sections
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 cen_in,
    input  wire                                 cen_out,
    input  wire  signed [snd_pkg::snd_w-1:0]    snd_in,
    output logic signed [snd_pkg::snd_w-1:0]    snd_out
);
    import snd_pkg::*;

    // dc gain is rate**(order-1), removed exactly by a shift
    localparam int gain_sh = $clog2(rate) * (order - 1);
    localparam int calc_w  = snd_w + gain_sh + 1;   // plus a guard bit

    logic signed [calc_w-1:0] comb_d [order];       // comb delays
    logic signed [calc_w-1:0] comb_v [order+1];     // comb chain values
    logic signed [calc_w-1:0] stuffed;              // zero stuffed stream
    logic signed [calc_w-1:0] integ  [order];       // integrators

    // comb chain at the low rate
    always_comb begin
        comb_v[0] = calc_w'(snd_in);                // sign extended
        for (int k = 0; k < order; k++) begin
            comb_v[k+1] = comb_v[k] - comb_d[k];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < order; k++) begin
                comb_d[k] <= '0;
            end
        end else if (cen_in) begin
            for (int k = 0; k < order; k++) begin
                comb_d[k] <= comb_v[k];
            end
        end
    end

    // one comb result per input sample, zeros in between
    assign stuffed = cen_in ? comb_v[order] : '0;

    // integrators and output at the high rate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < order; k++) begin
                integ[k] <= '0;
            end
            snd_out <= '0;
        end else if (cen_out) begin
            integ[0] <= integ[0] + stuffed;
            for (int k = 1; k < order; k++) begin
                integ[k] <= integ[k] + integ[k-1];  // pipelined cascade
            end
            snd_out <= snd_w'(integ[order-1] >>> gain_sh);  // fits once gain is removed
        end
    end

    // a low rate sample between output strobes would be dropped
    a_in_on_out: assert property (@(posedge clk) disable iff (!rst_n)
        cen_in |-> cen_out);

endmodule

`default_nettype wire

/* rtl/rate_strobes.sv */
// all rate strobes come from one counter; periods must be powers of two dividing in_period
`timescale 1ns/1ps
`default_nettype none

module rate_strobes (
    input  wire   clk,
    input  wire   rst_n,
    output logic  cen_in,
    output logic  cen_mid,
    output logic  cen_out
);
    import snd_pkg::*;

    localparam int in_b  = $clog2(in_period);
    localparam int mid_b = $clog2(mid_period);
    localparam int out_b = $clog2(out_period);

    logic [in_b-1:0] cnt;   // free running phase

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            cen_in  <= 1'b0;
            cen_mid <= 1'b0;
            cen_out <= 1'b0;
        end else begin
            if (cnt == in_b'(in_period - 1)) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // decoded from the same count so the domains stay phase locked
            cen_in  <= cnt == '0;
            cen_mid <= cnt[mid_b-1:0] == '0;
            cen_out <= cnt[out_b-1:0] == '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fm_uprate_top.sv */
// fm + psg up-rate top; sink takes every sample, no back-pressure, APB only for configuration
`timescale 1ns/1ps
`default_nettype none

module fm_uprate_top (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire  [apb_reg_pkg::apb_aw-1:0]      paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [apb_reg_pkg::apb_dw-1:0]      pwdata,
    output logic [apb_reg_pkg::apb_dw-1:0]      prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  wire  signed [snd_pkg::fm_w-1:0]     fm_snd,
    input  wire  signed [snd_pkg::psg_w-1:0]    psg_snd,
    output logic                                sample_tick,
    output logic signed [snd_pkg::snd_w-1:0]    snd,
    output logic                                snd_stb
);
    import snd_pkg::*;

    logic                    cen_in;
    logic                    cen_mid;
    logic                    cen_out;
    logic signed [snd_w-1:0] mixed_snd;   // input rate
    logic signed [snd_w-1:0] mid_snd;     // after x4

    mix_cfg_if u_cfg ();

    apb_cfg_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (u_cfg.regs)
    );

    rate_strobes u_strobes (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen_in  (cen_in),
        .cen_mid (cen_mid),
        .cen_out (cen_out)
    );

    snd_mixer u_mixer (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen_in  (cen_in),
        .fm_snd  (fm_snd),
        .psg_snd (psg_snd),
        .cfg     (u_cfg.mixer),
        .mixed   (mixed_snd)
    );

    // input rate to mid rate, sample hold
    cic_interp #(.rate(s1_rate), .order(s1_order)) u_stage1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen_in  (cen_in),
        .cen_out (cen_mid),
        .snd_in  (mixed_snd),
        .snd_out (mid_snd)
    );

    // mid rate to output rate, linear ramps
    cic_interp #(.rate(s2_rate), .order(s2_order)) u_stage2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .cen_in  (cen_mid),
        .cen_out (cen_out),
        .snd_in  (mid_snd),
        .snd_out (snd)
    );

    // strobes line up with the registered outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_tick <= 1'b0;
            snd_stb     <= 1'b0;
        end else begin
            sample_tick <= cen_in;    // input just taken
            snd_stb     <= cen_out;   // snd just updated
        end
    end

endmodule

`default_nettype wire

/* verif/tb_fm_uprate.sv */
// trace driven testbench; run from the project root; trace holds count input periods of 32 clocks
`timescale 1ns/1ps
`default_nettype none

module tb_fm_uprate;
    import snd_pkg::*;
    import apb_reg_pkg::*;

    localparam int clk_half   = 10;     // 20 ns clock
    localparam int rst_cycles = 10;
    localparam int max_lines  = 64;
    localparam int margin     = 400;    // reset, pipeline fill and slack

    logic                     clk;
    logic                     rst_n;
    logic [apb_aw-1:0]        paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [apb_dw-1:0]        pwdata;
    logic [apb_dw-1:0]        prdata;
    logic                     pready;
    logic                     pslverr;
    logic signed [fm_w-1:0]   fm_snd;
    logic signed [psg_w-1:0]  psg_snd;
    logic                     sample_tick;
    logic signed [snd_w-1:0]  snd;
    logic                     snd_stb;

    // trace held in memory and loaded before reset ends
    string       tr_op   [max_lines];
    logic [31:0] tr_a    [max_lines];   // address or fm sample
    logic [31:0] tr_d    [max_lines];   // data, psg sample or expected snd
    int          tr_hold [max_lines];   // input periods
    string       tr_name [max_lines];
    int          n_lines   = 0;

    int          cyc       = 0;         // clocks since reset release
    int          limit     = 0;         // 0 until the trace is loaded
    int          last_stb  = -1;
    int          last_tick = -1;
    int          errors    = 0;
    logic [31:0] rng_state;

    fm_uprate_top i_fm_uprate_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .fm_snd      (fm_snd),
        .psg_snd     (psg_snd),
        .sample_tick (sample_tick),
        .snd         (snd),
        .snd_stb     (snd_stb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    task automatic fail_now(input string what);
        errors++;
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic is_mapped(input logic [apb_aw-1:0] a);
        return a == ctrl_addr || a == status_addr || a == id_addr;
    endfunction

    // random address outside the register map
    function automatic logic [apb_aw-1:0] pick_unmapped();
        logic [apb_aw-1:0] a;
        rng_state = xorshift32(rng_state);
        a = rng_state[apb_aw-1:0];
        while (is_mapped(a)) begin
            rng_state = xorshift32(rng_state);
            a = rng_state[apb_aw-1:0];
        end
        return a;
    endfunction

    // zero wait transfer with the response sampled mid access phase
    task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] a,
                            input logic [apb_dw-1:0] d, output logic [apb_dw-1:0] rd,
                            output logic err);
        @(negedge clk);
        paddr   = a;
        pwdata  = d;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;             // setup
        @(negedge clk);
        penable = 1'b1;             // access
        #(clk_half / 2);
        assert (pready) else fail_now("pready low in the access phase");
        rd  = prdata;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic hold_periods(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (sample_tick) begin
                seen++;
            end
        end
    endtask

    // every output sample in the window must sit at the settled level
    task automatic check_level(input logic [snd_w-1:0] exp, input int n, input string name);
        int seen;
        int hits;
        seen = 0;
        hits = 0;
        while (seen < n) begin
            @(negedge clk);
            if (sample_tick) begin
                seen++;
            end
            if (snd_stb) begin
                hits++;
                assert (snd == exp) else
                    fail_now($sformatf("Mismatch %s expected %h actual %h", name, exp, snd));
            end
        end
        assert (hits > 0) else fail_now($sformatf("no output strobe seen in %s", name));
    endtask

    task automatic load_trace();
        int          fd;
        int          cnt;
        string       line;
        string       op;
        string       name;
        logic [31:0] a;
        logic [31:0] d;
        int          h;
        fd = $fopen("verif/uprate_trace.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open trace file verif/uprate_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;                           // blank or column notes
            end
            cnt = $sscanf(line, "%s %h %h %d %s", op, a, d, h, name);
            if (cnt != 5) begin
                fail_now($sformatf("malformed trace line: %s", line));
            end
            if (n_lines >= max_lines) begin
                fail_now("trace has more lines than the testbench can hold");
            end
            tr_op[n_lines]   = op;
            tr_a[n_lines]    = a;
            tr_d[n_lines]    = d;
            tr_hold[n_lines] = h;
            tr_name[n_lines] = name;
            n_lines++;
        end
        $fclose(fd);
    endtask

    task automatic run_line(input int i);
        logic              err;
        logic [apb_dw-1:0] rd;
        logic [apb_aw-1:0] bad_a;
        if (tr_op[i] == "write") begin
            apb_xfer(1'b1, tr_a[i][apb_aw-1:0], tr_d[i], rd, err);
            assert (!err) else fail_now($sformatf("pslverr on mapped write in %s", tr_name[i]));
        end else if (tr_op[i] == "read") begin
            apb_xfer(1'b0, tr_a[i][apb_aw-1:0], '0, rd, err);
            assert (!err) else fail_now($sformatf("pslverr on mapped read in %s", tr_name[i]));
            assert (rd == tr_d[i]) else
                fail_now($sformatf("Mismatch %s expected %h actual %h", tr_name[i], tr_d[i], rd));
        end else if (tr_op[i] == "sample") begin
            @(negedge clk);
            fm_snd  = tr_a[i][fm_w-1:0];
            psg_snd = tr_d[i][psg_w-1:0];
            hold_periods(tr_hold[i]);
        end else if (tr_op[i] == "expect") begin
            check_level(tr_d[i][snd_w-1:0], tr_hold[i], tr_name[i]);
        end else if (tr_op[i] == "badaddr") begin
            bad_a = pick_unmapped();
            apb_xfer(1'b1, bad_a, tr_d[i], rd, err);
            assert (err) else fail_now($sformatf("no pslverr on write to %h", bad_a));
            apb_xfer(1'b0, bad_a, '0, rd, err);
            assert (err) else fail_now($sformatf("no pslverr on read of %h", bad_a));
            assert (rd == '0) else
                fail_now($sformatf("Mismatch %s expected %h actual %h", tr_name[i], 32'h0, rd));
        end else begin
            fail_now($sformatf("unknown trace operation %s", tr_op[i]));
        end
    endtask

    // strobe spacing and run limit
    always @(negedge clk) begin
        if (rst_n) begin
            cyc = cyc + 1;
            if (snd_stb) begin
                if (last_stb >= 0) begin
                    assert (cyc - last_stb == out_period) else
                        fail_now($sformatf("Mismatch snd_stb_spacing expected %0d actual %0d",
                                           out_period, cyc - last_stb));
                end
                last_stb = cyc;
            end
            if (sample_tick) begin
                if (last_tick >= 0) begin
                    assert (cyc - last_tick == in_period) else
                        fail_now($sformatf("Mismatch tick_spacing expected %0d actual %0d",
                                           in_period, cyc - last_tick));
                end
                last_tick = cyc;
            end
            if (limit > 0 && cyc > limit) begin
                fail_now($sformatf("timeout, trace not finished after %0d cycles", cyc));
            end
        end
    end

    initial begin
        int total;
        rst_n     = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        fm_snd    = '0;
        psg_snd   = '0;
        rng_state = 32'd50;
        load_trace();
        total = 0;
        for (int i = 0; i < n_lines; i++) begin
            total += tr_hold[i];
        end
        limit = total * in_period + n_lines * 8 + margin;   // apb ops take about 4 clocks
        repeat (rst_cycles) @(negedge clk);
        assert (snd == '0) else
            fail_now($sformatf("Mismatch reset_snd expected %h actual %h", 16'h0, snd));
        assert (!snd_stb && !sample_tick && !pslverr) else
            fail_now("strobes or pslverr not low in reset");
        rst_n = 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/uprate_trace.txt */
# op addr_or_fm data_or_psg hold name; hex, hex, decimal input periods, text
# write/read: APB access and read data; sample: drive fm, psg; expect: snd at every snd_stb
read     00    00000003  0  rst_ctrl
read     04    00000000  0  rst_status
read     08    464d5552  0  rst_id
write    00    00000001  0  fm_only_cfg
sample   1234  7ff       3  fm_pos
expect   0     1234      1  fm_pos
sample   c000  7ff       3  fm_neg
expect   0     c000      1  fm_neg
write    00    00000002  0  psg_att0_cfg
sample   7fff  123       3  psg_att0
expect   0     0246      1  psg_att0
write    00    00000006  0  psg_att1_cfg
sample   7fff  e45       3  psg_att1
expect   0     fe45      1  psg_att1
write    00    0000000a  0  psg_att2_cfg
sample   7fff  e45       3  psg_att2
expect   0     ff22      1  psg_att2
write    00    0000000e  0  psg_att3_cfg
sample   7fff  123       3  psg_att3
expect   0     0048      1  psg_att3
write    00    00000000  0  all_off_cfg
sample   1234  123       3  all_off
expect   0     0000      1  all_off
write    00    00000003  0  both_cfg
sample   7f00  7ff       3  sat_pos
expect   0     7fff      1  sat_pos
read     04    00000001  0  clip_set
sample   8100  800       3  sat_neg
expect   0     8000      1  sat_neg
sample   0100  010       3  in_range
write    04    00000001  0  clip_clear
read     04    00000000  0  clip_cleared
expect   0     0120      1  in_range
read     04    00000000  0  clip_stays_clear
badaddr  0     0000000f  0  bad_addr1
badaddr  0     0000000f  0  bad_addr2
read     00    00000003  0  ctrl_unchanged

/* tb.f */
rtl/snd_pkg.sv
rtl/apb_reg_pkg.sv
rtl/mix_cfg_if.sv
rtl/apb_cfg_regs.sv
rtl/snd_mixer.sv
rtl/cic_interp.sv
rtl/rate_strobes.sv
rtl/fm_uprate_top.sv
verif/tb_fm_uprate.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fm_uprate
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the trace driven testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
